//--- hw/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

   //////////////////////////////
   // Widths and constants
   //////////////////////////////

   // Datapath word and register file sizes
   localparam int WORD_W    = 16;
   localparam int REG_IDX_W = 3;
   localparam int OPC_W     = 5;

   // Byte address step between instructions
   localparam int PC_STEP = 2;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [REG_IDX_W-1:0] reg_idx_t;

   // Bubble word pushed down the pipe
   localparam word_t NOP_INSTR = 16'h0800;

   // Opcode values
   localparam logic [OPC_W-1:0] OPC_HALT = 5'b00000;
   // Control transfers, matched on the top three opcode bits
   localparam logic [2:0] OPC_PFX_JUMP   = 3'b011;
   localparam logic [2:0] OPC_PFX_BRANCH = 3'b001;

   //////////////////////////////
   // Bundles
   //////////////////////////////

   // Sources read by the word at the PC
   typedef struct packed {
      reg_idx_t rs;
      reg_idx_t rt;
      logic     rs_valid;
      logic     rt_valid;
   } src_regs_t;

   // Destination written by a later stage
   typedef struct packed {
      reg_idx_t idx;
      logic     valid;
   } dest_report_t;

   // Registered stage result
   typedef struct packed {
      word_t instr;
      word_t pc_next;
   } fetch_out_t;

   // Instruction memory fill request, addr is a word index
   typedef struct packed {
      logic  en;
      word_t addr;
      word_t data;
   } imem_load_t;

endpackage

`default_nettype wire

//--- hw/instr_mem.sv
`timescale 1ns/1ps
`default_nettype none

module instr_mem
   import fetch_pkg::*;
#(
   parameter int MEM_WORDS = 256
) (
   input  wire        clk,
   input  imem_load_t load,
   input  word_t      addr,
   output word_t      rdata
);

   // Index bits needed for the array
   localparam int IDX_W = $clog2(MEM_WORDS);

   //////////////////////////////
   // Storage
   //////////////////////////////

   // Program words, filled through the load port
   word_t mem [MEM_WORDS];

   // Byte address to word index
   word_t rd_idx;

   assign rd_idx = {1'b0, addr[WORD_W-1:1]};

   // Load port, writes past the end are dropped
   always_ff @(posedge clk) begin
      if (load.en && (load.addr < MEM_WORDS)) begin
         mem[load.addr[IDX_W-1:0]] <= load.data;
      end
   end

   //////////////////////////////
   // Read
   //////////////////////////////

   // Same-cycle read
   always_comb begin
      if (rd_idx < MEM_WORDS) begin
         rdata = mem[rd_idx[IDX_W-1:0]];
      end else begin
         // Outside the array, feed a bubble
         rdata = NOP_INSTR;
      end
   end

endmodule

`default_nettype wire

//--- hw/raw_detector.sv
`timescale 1ns/1ps
`default_nettype none

module raw_detector
   import fetch_pkg::*;
#(
   parameter int HIST_DEPTH = 2
) (
   input  wire          clk,
   input  wire          arst_n,
   input  dest_report_t dest,
   input  src_regs_t    srcs,
   output logic         hazard
);

   //////////////////////////////
   // Destination history
   //////////////////////////////

   // Entry 0 holds the newest report
   dest_report_t hist [HIST_DEPTH];

   // One report shifted in per clock
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < HIST_DEPTH; i++) begin
            hist[i] <= '0;
         end
      end else begin
         hist[0] <= dest;
         // Older entries move down, last one falls off
         for (int i = 1; i < HIST_DEPTH; i++) begin
            hist[i] <= hist[i-1];
         end
      end
   end

   //////////////////////////////
   // Compare against sources
   //////////////////////////////

   always_comb begin
      logic hit;
      hit = 1'b0;
      for (int i = 0; i < HIST_DEPTH; i++) begin
         // Only entries that really write a register
         if (hist[i].valid) begin
            // rs read
            if (srcs.rs_valid && (srcs.rs == hist[i].idx)) begin
               hit = 1'b1;
            end
            // rt read
            if (srcs.rt_valid && (srcs.rt == hist[i].idx)) begin
               hit = 1'b1;
            end
         end
      end
      hazard = hit;
   end

endmodule

`default_nettype wire

//--- hw/fetch.sv
`timescale 1ns/1ps
`default_nettype none

module fetch
   import fetch_pkg::*;
(
   input  wire        clk,
   input  wire        arst_n,
   input  logic       jump_valid,
   input  word_t      jump_pc,
   input  logic       hazard,
   output word_t      imem_addr,
   input  word_t      imem_rdata,
   output src_regs_t  srcs,
   output fetch_out_t fetch_q,
   output logic       dump
);

   //////////////////////////////
   // State
   //////////////////////////////

   // Byte address of the word being fetched
   word_t pc;
   word_t pc_d;
   word_t pc_plus2;

   // Halt seen, frozen until reset
   logic halted;
   logic halted_d;

   // Control transfer issued, waiting on a redirect
   logic wait_jmp;
   logic wait_jmp_d;

   fetch_out_t q_d;

   // Opcode of the current word
   logic [OPC_W-1:0] opcode;
   logic             is_halt;
   logic             is_ctrl;

   assign pc_plus2  = pc + word_t'(PC_STEP);
   assign imem_addr = pc;
   assign opcode    = imem_rdata[WORD_W-1:WORD_W-OPC_W];

   assign is_halt = (opcode == OPC_HALT);
   // Jumps and branches
   assign is_ctrl = (opcode[OPC_W-1:OPC_W-3] == OPC_PFX_JUMP)
                 || (opcode[OPC_W-1:OPC_W-3] == OPC_PFX_BRANCH);

   //////////////////////////////
   // Source decode
   //////////////////////////////

   assign srcs.rs = imem_rdata[10:8];
   assign srcs.rt = imem_rdata[7:5];
   // No rs for the 000 group or for 001 with bit 11 low
   assign srcs.rs_valid = (imem_rdata[15:13] != 3'b000)
                       && ({imem_rdata[15:13], imem_rdata[11]} != 4'b0010);
   // rt read by 1101 and the 111 group
   assign srcs.rt_valid = (imem_rdata[15:12] == 4'b1101)
                       || (imem_rdata[15:13] == 3'b111);

   //////////////////////////////
   // Next state
   //////////////////////////////

   always_comb begin
      // Default is hold with a bubble
      pc_d          = pc;
      halted_d      = halted;
      wait_jmp_d    = wait_jmp;
      q_d.instr     = NOP_INSTR;
      q_d.pc_next   = pc_plus2;
      if (!halted) begin
         if (!wait_jmp && is_halt) begin
            // Pass halt once, wins over redirect
            q_d.instr = imem_rdata;
            halted_d  = 1'b1;
         end else if (jump_valid) begin
            // Redirect, overrides hazard and wait
            pc_d       = jump_pc;
            wait_jmp_d = 1'b0;
         end else if (!wait_jmp && !hazard) begin
            // Normal flow
            q_d.instr = imem_rdata;
            pc_d      = pc_plus2;
            // Stall behind a control transfer
            if (is_ctrl) begin
               wait_jmp_d = 1'b1;
            end
         end
      end
   end

   //////////////////////////////
   // Registers
   //////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pc       <= '0;
         halted   <= 1'b0;
         wait_jmp <= 1'b0;
      end else begin
         pc       <= pc_d;
         halted   <= halted_d;
         wait_jmp <= wait_jmp_d;
      end
   end

   // Pipe toward decode, bubble out of reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fetch_q.instr   <= NOP_INSTR;
         fetch_q.pc_next <= '0;
      end else begin
         fetch_q <= q_d;
      end
   end

   // Memory dump request
   assign dump = halted;

endmodule

`default_nettype wire

//--- hw/fetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_top
   import fetch_pkg::*;
#(
   parameter int MEM_WORDS  = 256,
   parameter int HIST_DEPTH = 2
) (
   input  wire          clk,
   input  wire          arst_n,
   input  imem_load_t   load,
   input  dest_report_t dest,
   input  logic         jump_valid,
   input  word_t        jump_pc,
   output fetch_out_t   fetch_q,
   output src_regs_t    srcs,
   output logic         dump
);

   // PC toward memory and word back
   word_t imem_addr;
   word_t imem_rdata;
   // RAW stall request
   logic  hazard;

   //////////////////////////////
   // Instances
   //////////////////////////////

   instr_mem #(
      .MEM_WORDS (MEM_WORDS)
   ) instr_mem_inst (
      .clk   (clk),
      .load  (load),
      .addr  (imem_addr),
      .rdata (imem_rdata)
   );

   raw_detector #(
      .HIST_DEPTH (HIST_DEPTH)
   ) raw_detector_inst (
      .clk    (clk),
      .arst_n (arst_n),
      .dest   (dest),
      .srcs   (srcs),
      .hazard (hazard)
   );

   fetch fetch_inst (
      .clk        (clk),
      .arst_n     (arst_n),
      .jump_valid (jump_valid),
      .jump_pc    (jump_pc),
      .hazard     (hazard),
      .imem_addr  (imem_addr),
      .imem_rdata (imem_rdata),
      .srcs       (srcs),
      .fetch_q    (fetch_q),
      .dump       (dump)
   );

endmodule

`default_nettype wire

//--- verification/fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_tb
   import fetch_pkg::*;
();

   localparam int CLK_PERIOD = 40;
   localparam int MEM_WORDS  = 256;
   localparam int HIST_DEPTH = 2;
   // Under 40 cycles per test, five tests, plus slack
   localparam int RUN_CYCLES = 5 * 40 + 50;

   logic         clk;
   logic         arst_n;
   imem_load_t   load_req;
   dest_report_t dest;
   logic         jump_valid;
   word_t        jump_pc;
   fetch_out_t   fetch_q;
   src_regs_t    srcs;
   logic         dump;

   int    error_count;
   // Program image for the next load
   word_t prog [$];

   fetch_top #(
      .MEM_WORDS  (MEM_WORDS),
      .HIST_DEPTH (HIST_DEPTH)
   ) fetch_top_inst (
      .clk        (clk),
      .arst_n     (arst_n),
      .load       (load_req),
      .dest       (dest),
      .jump_valid (jump_valid),
      .jump_pc    (jump_pc),
      .fetch_q    (fetch_q),
      .srcs       (srcs),
      .dump       (dump)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // Watchdog
   initial begin
      #(CLK_PERIOD * RUN_CYCLES);
      $display("Timeout: tests did not complete within %0d clock cycles", RUN_CYCLES);
      $display("Finished with errors");
      $fatal(1, "watchdog expired");
   end

   //////////////////////////////
   // Helpers
   //////////////////////////////

   // Drive point, 2 ns past the edge
   task automatic drive_edge();
      @(posedge clk);
      #2;
   endtask

   // From the drive point to just before the next edge
   task automatic sample_wait();
      #(CLK_PERIOD - 4);
   endtask

   task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
      if (actual !== expected) begin
         error_count++;
         $display("FAIL at %0d ns: %s, got %h expected %h", $time, what, actual, expected);
         $display("Finished with errors");
         $fatal(1, "value mismatch");
      end
   endtask

   // Opcode 00001 with random low bits, no sources and no control transfer
   function automatic word_t filler_word();
      logic [31:0] r;
      r = $urandom;
      return {5'b00001, r[10:0]};
   endfunction

   // Sources by the encoding rules
   function automatic src_regs_t expect_srcs(input word_t w);
      src_regs_t e;
      e.rs = w[10:8];
      e.rt = w[7:5];
      case (w[15:13])
         3'b000:  e.rs_valid = 1'b0;
         3'b001:  e.rs_valid = w[11];
         default: e.rs_valid = 1'b1;
      endcase
      case (w[15:12])
         4'b1101, 4'b1110, 4'b1111: e.rt_valid = 1'b1;
         default:                   e.rt_valid = 1'b0;
      endcase
      return e;
   endfunction

   task automatic load_program();
      foreach (prog[i]) begin
         load_req.en   = 1'b1;
         load_req.addr = word_t'(i);
         load_req.data = prog[i];
         drive_edge();
      end
      load_req = '0;
   endtask

   // Eight cycles of reset, outputs checked throughout
   task automatic apply_reset();
      arst_n = 1'b0;
      repeat (8) begin
         sample_wait();
         check_value(32'(fetch_q.instr), 32'(NOP_INSTR), "instr in reset");
         check_value(32'(fetch_q.pc_next), 32'd0, "pc_next in reset");
         check_value(32'(dump), 32'd0, "dump in reset");
         drive_edge();
      end
      arst_n = 1'b1;
   endtask

   // Check the last registered result, then move on one edge
   task automatic expect_out(input word_t instr, input word_t pc_next, input bit chk_pc,
                             input bit exp_dump, input string what);
      sample_wait();
      check_value(32'(fetch_q.instr), 32'(instr), {what, " instr"});
      if (chk_pc) begin
         check_value(32'(fetch_q.pc_next), 32'(pc_next), {what, " pc_next"});
      end
      check_value(32'(dump), 32'(exp_dump), {what, " dump"});
      drive_edge();
   endtask

   //////////////////////////////
   // Tests
   //////////////////////////////

   task automatic test_sequential();
      prog.delete();
      repeat (8) prog.push_back(filler_word());
      load_program();
      apply_reset();
      drive_edge();
      foreach (prog[i]) begin
         expect_out(prog[i], word_t'(2 * i + 2), 1'b1, 1'b0, "sequential");
      end
   endtask

   // Control transfers go last since the flow stops behind the first
   task automatic test_decode();
      prog = {16'h1234, 16'hD2A0, 16'hC3A0, 16'hE4C0, 16'h8560, 16'hA1E0,
              16'h4BE0, 16'hF7FF, 16'h0FFF, 16'h2B40, 16'h2340};
      load_program();
      apply_reset();
      foreach (prog[i]) begin
         sample_wait();
         check_value(32'(srcs), 32'(expect_srcs(prog[i])), "source decode");
         drive_edge();
      end
   endtask

   task automatic test_hazard();
      prog.delete();
      prog.push_back(filler_word());
      // Reads r3
      prog.push_back(16'h8300);
      prog.push_back(filler_word());
      load_program();
      apply_reset();
      dest = '{idx: 3'd3, valid: 1'b1};
      drive_edge();
      dest = '0;
      expect_out(prog[0], 16'd2, 1'b1, 1'b0, "before hazard");
      // One bubble per edge the report stays in the window
      repeat (HIST_DEPTH) expect_out(NOP_INSTR, '0, 1'b0, 1'b0, "hazard bubble");
      expect_out(prog[1], 16'd4, 1'b1, 1'b0, "held word");
      expect_out(prog[2], 16'd6, 1'b1, 1'b0, "after hazard");
   endtask

   task automatic test_redirect();
      prog.delete();
      prog.push_back(filler_word());
      prog.push_back(16'h6000);
      repeat (5) prog.push_back(filler_word());
      load_program();
      apply_reset();
      drive_edge();
      expect_out(prog[0], 16'd2, 1'b1, 1'b0, "before jump");
      expect_out(prog[1], 16'd4, 1'b1, 1'b0, "jump word");
      repeat (3) expect_out(NOP_INSTR, '0, 1'b0, 1'b0, "waiting");
      // Target is word 6
      jump_valid = 1'b1;
      jump_pc    = 16'd12;
      expect_out(NOP_INSTR, '0, 1'b0, 1'b0, "waiting");
      jump_valid = 1'b0;
      expect_out(NOP_INSTR, '0, 1'b0, 1'b0, "redirect edge");
      expect_out(prog[6], 16'd14, 1'b1, 1'b0, "jump target");
   endtask

   task automatic test_halt();
      prog.delete();
      prog.push_back(filler_word());
      prog.push_back(16'h0123);
      prog.push_back(filler_word());
      prog.push_back(filler_word());
      load_program();
      apply_reset();
      drive_edge();
      expect_out(prog[0], 16'd2, 1'b1, 1'b0, "before halt");
      expect_out(prog[1], 16'd4, 1'b1, 1'b1, "halt word");
      repeat (2) expect_out(NOP_INSTR, '0, 1'b0, 1'b1, "halted");
      // Redirect must be ignored
      jump_valid = 1'b1;
      jump_pc    = 16'd4;
      expect_out(NOP_INSTR, '0, 1'b0, 1'b1, "halted");
      jump_valid = 1'b0;
      repeat (4) expect_out(NOP_INSTR, '0, 1'b0, 1'b1, "halted after jump");
   endtask

   initial begin
      clk         = 1'b0;
      arst_n      = 1'b0;
      load_req    = '0;
      dest        = '0;
      jump_valid  = 1'b0;
      jump_pc     = '0;
      error_count = 0;
      void'($urandom(6));
      drive_edge();
      test_sequential();
      test_decode();
      test_hazard();
      test_redirect();
      test_halt();
      if (error_count == 0) begin
         $display("Finished with no errors");
         $finish;
      end else begin
         $display("Finished with errors");
         $fatal(1, "errors found");
      end
   end

endmodule

`default_nettype wire

//--- src.f
hw/fetch_pkg.sv
hw/instr_mem.sv
hw/raw_detector.sv
hw/fetch.sv
hw/fetch_top.sv
verification/fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the fetch stage testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module fetch_tb -Mdir obj_dir -o fetch_sim

# $fatal exits nonzero, the log decides the result
./obj_dir/fetch_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
   echo "Simulation FAILED, see $LOG"
   exit 1
fi
echo "Simulation passed"
